//--- Bender.yml
package:
  name: muldiv

sources:
  - logic/muldiv_pkg.sv
  - logic/hilo_wb_if.sv
  - logic/seq_divider.sv
  - logic/muldiv_unit.sv
  - logic/hilo_regs.sv
  - logic/muldiv_top.sv
  - target: test
    files:
      - tests/muldiv_sva.sv
      - tests/tb_muldiv.sv

//--- logic/hilo_regs.sv
`timescale 1ns/10ps
`default_nettype none

module hilo_regs import muldiv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mthi,
    input  logic              mtlo,
    input  logic [DATA_W-1:0] move_data,
    hilo_wb_if.regs           wb,
    output logic [DATA_W-1:0] hi,
    output logic [DATA_W-1:0] lo
);

    // A result writeback wins over a software move in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (wb.wb_valid) begin
            hi <= wb.wb_hi;
            lo <= wb.wb_lo;
        end else begin
            if (mthi) begin
                hi <= move_data;
            end
            if (mtlo) begin
                lo <= move_data;
            end
        end
    end

    assign wb.cur_hi = hi;  // Accumulate source for MADD and MSUB.
    assign wb.cur_lo = lo;

endmodule

`default_nettype wire

//--- logic/hilo_wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface hilo_wb_if import muldiv_pkg::*; ();

    logic              wb_valid;  // One cycle, on the response transfer edge.
    logic [DATA_W-1:0] wb_hi;
    logic [DATA_W-1:0] wb_lo;

    // Architectural contents, fed back for MADD and MSUB.
    logic [DATA_W-1:0] cur_hi;
    logic [DATA_W-1:0] cur_lo;

    modport unit (
        output wb_valid,
        output wb_hi,
        output wb_lo,
        input  cur_hi,
        input  cur_lo
    );

    modport regs (
        input  wb_valid,
        input  wb_hi,
        input  wb_lo,
        output cur_hi,
        output cur_lo
    );

endinterface

`default_nettype wire

//--- logic/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    localparam int DATA_W = 32;
    localparam int WIDE_W = 2 * DATA_W;

    // One quotient bit per iteration.
    localparam int DIV_CYCLES = DATA_W;

    // Acceptance to resp_valid, counting the divider load and the result signing cycle.
    localparam int DIV_LATENCY = DIV_CYCLES + 2;

    // Signed or unsigned is carried by a separate flag.
    typedef enum logic [2:0] {
        OP_MULT = 3'd0,
        OP_MADD = 3'd1,
        OP_MSUB = 3'd2,
        OP_MUL  = 3'd3,
        OP_DIV  = 3'd4
    } muldiv_op_e;

    // Magnitude of an operand, or the operand itself in unsigned mode.
    function automatic logic [DATA_W-1:0] magnitude(input logic [DATA_W-1:0] value,
                                                    input logic            is_unsigned);
        logic [DATA_W-1:0] result;
        if (is_unsigned || !value[DATA_W-1]) begin
            result = value;
        end else begin
            result = -value;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- logic/muldiv_top.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_top import muldiv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              req_valid,
    output logic              req_ready,
    input  muldiv_op_e        req_op,
    input  logic              req_unsigned,
    input  logic [DATA_W-1:0] req_a,
    input  logic [DATA_W-1:0] req_b,
    output logic              resp_valid,
    input  logic              resp_ready,
    output logic [DATA_W-1:0] resp_hi,
    output logic [DATA_W-1:0] resp_lo,
    input  logic              mthi,
    input  logic              mtlo,
    input  logic [DATA_W-1:0] move_data,
    output logic [DATA_W-1:0] hi,
    output logic [DATA_W-1:0] lo
);

    logic              div_start;
    logic              div_abort;
    logic              div_busy;  // Observed by the bound assertions.
    logic              div_done;
    logic [DATA_W-1:0] div_numer;
    logic [DATA_W-1:0] div_denom;
    logic [DATA_W-1:0] div_quotient;
    logic [DATA_W-1:0] div_remain;

    hilo_wb_if hilo_wb ();

    muldiv_unit u_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_unsigned (req_unsigned),
        .req_a        (req_a),
        .req_b        (req_b),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_hi      (resp_hi),
        .resp_lo      (resp_lo),
        .wb           (hilo_wb.unit),
        .div_start    (div_start),
        .div_abort    (div_abort),
        .div_numer    (div_numer),
        .div_denom    (div_denom),
        .div_done     (div_done),
        .div_quotient (div_quotient),
        .div_remain   (div_remain)
    );

    seq_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .abort    (div_abort),
        .start    (div_start),
        .numer    (div_numer),
        .denom    (div_denom),
        .busy     (div_busy),
        .done     (div_done),
        .quotient (div_quotient),
        .remain   (div_remain)
    );

    hilo_regs u_hilo (
        .clk       (clk),
        .rst_n     (rst_n),
        .mthi      (mthi),
        .mtlo      (mtlo),
        .move_data (move_data),
        .wb        (hilo_wb.regs),
        .hi        (hi),
        .lo        (lo)
    );

endmodule

`default_nettype wire

//--- logic/muldiv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              req_valid,
    output logic              req_ready,
    input  muldiv_op_e        req_op,
    input  logic              req_unsigned,
    input  logic [DATA_W-1:0] req_a,
    input  logic [DATA_W-1:0] req_b,
    output logic              resp_valid,
    input  logic              resp_ready,
    output logic [DATA_W-1:0] resp_hi,
    output logic [DATA_W-1:0] resp_lo,
    hilo_wb_if.unit           wb,
    output logic              div_start,
    output logic              div_abort,
    output logic [DATA_W-1:0] div_numer,
    output logic [DATA_W-1:0] div_denom,
    input  logic              div_done,
    input  logic [DATA_W-1:0] div_quotient,
    input  logic [DATA_W-1:0] div_remain
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_RESP
    } state_e;

    state_e state;

    logic              accept;
    logic [DATA_W-1:0] mag_a;
    logic [DATA_W-1:0] mag_b;
    logic              prod_neg;
    logic [WIDE_W-1:0] prod_mag;
    logic [WIDE_W-1:0] prod_val;
    logic [WIDE_W-1:0] hilo_cur;
    logic [WIDE_W-1:0] mul_result;

    // Captured request state, needed for the divider sign fixup and the writeback.
    logic              uns_q;
    logic              a_sign_q;
    logic              b_sign_q;
    logic              wb_en_q;  // Clear for MUL, which leaves HI/LO alone.

    logic              quot_neg;
    logic              rem_neg;
    logic [DATA_W-1:0] quot_val;
    logic [DATA_W-1:0] rem_val;

    // A request seen together with a flush is not taken.
    assign req_ready  = (state == S_IDLE) && !flush;
    assign accept     = req_valid && req_ready;
    assign resp_valid = (state == S_RESP);

    assign mag_a    = magnitude(req_a, req_unsigned);
    assign mag_b    = magnitude(req_b, req_unsigned);
    assign prod_neg = !req_unsigned && (req_a[DATA_W-1] ^ req_b[DATA_W-1]);
    assign prod_mag = {{DATA_W{1'b0}}, mag_a} * {{DATA_W{1'b0}}, mag_b};
    assign prod_val = prod_neg ? -prod_mag : prod_mag;
    assign hilo_cur = {wb.cur_hi, wb.cur_lo};

    always_comb begin
        case (req_op)
            OP_MADD: mul_result = hilo_cur + prod_val;
            OP_MSUB: mul_result = hilo_cur - prod_val;
            default: mul_result = prod_val;  // MULT and MUL.
        endcase
    end

    assign quot_neg = !uns_q && (a_sign_q ^ b_sign_q);
    assign rem_neg  = !uns_q && a_sign_q;  // The remainder follows the dividend.
    assign quot_val = quot_neg ? -div_quotient : div_quotient;
    assign rem_val  = rem_neg ? -div_remain : div_remain;

    // The divider loads its magnitudes on the acceptance edge.
    assign div_start = accept && (req_op == OP_DIV);
    assign div_abort = flush;
    assign div_numer = mag_a;
    assign div_denom = mag_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (flush) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= (req_op == OP_DIV) ? S_RUN : S_RESP;
                    end
                end
                S_RUN: begin
                    if (div_done) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (resp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uns_q    <= req_unsigned;
            a_sign_q <= req_a[DATA_W-1];
            b_sign_q <= req_b[DATA_W-1];
            wb_en_q  <= (req_op != OP_MUL);
        end
    end

    // Response buffer. It is held untouched while S_RESP waits for resp_ready.
    always_ff @(posedge clk) begin
        if (accept && req_op != OP_DIV) begin
            {resp_hi, resp_lo} <= mul_result;
        end else if (state == S_RUN && div_done) begin
            resp_hi <= rem_val;
            resp_lo <= quot_val;
        end
    end

    assign wb.wb_valid = resp_valid && resp_ready && wb_en_q && !flush;
    assign wb.wb_hi    = resp_hi;
    assign wb.wb_lo    = resp_lo;

endmodule

`default_nettype wire

//--- logic/seq_divider.sv
`timescale 1ns/10ps
`default_nettype none

module seq_divider import muldiv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              abort,
    input  logic              start,
    input  logic [DATA_W-1:0] numer,
    input  logic [DATA_W-1:0] denom,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] quotient,
    output logic [DATA_W-1:0] remain
);

    logic [DIV_CYCLES-1:0] stage;  // One-hot, shifts right once per quotient bit.
    logic [DATA_W-1:0]     denom_q;
    logic [DATA_W:0]       trial;

    assign busy = |stage;

    // Shift the next dividend bit into the partial remainder and try the subtraction.
    assign trial = {remain, quotient[DATA_W-1]} - {1'b0, denom_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
            done  <= 1'b0;
        end else if (abort) begin
            stage <= '0;
            done  <= 1'b0;
        end else begin
            done <= stage[0];  // The last iteration completes on this edge.
            if (start) begin
                stage <= {1'b1, {(DIV_CYCLES-1){1'b0}}};
            end else begin
                stage <= stage >> 1;
            end
        end
    end

    // The quotient register starts out holding the dividend and fills from the right.
    always_ff @(posedge clk) begin
        if (start) begin
            remain   <= '0;
            quotient <= numer;
            denom_q  <= denom;
        end else if (busy) begin
            if (!trial[DATA_W]) begin
                remain   <= trial[DATA_W-1:0];
                quotient <= {quotient[DATA_W-2:0], 1'b1};
            end else begin
                // Restore. The partial remainder keeps the shifted value.
                remain   <= {remain[DATA_W-2:0], quotient[DATA_W-1]};
                quotient <= {quotient[DATA_W-2:0], 1'b0};
            end
        end
    end

    // A zero divisor never restores, so the quotient ends as all ones and the
    // remainder as the dividend.

endmodule

`default_nettype wire

//--- tb.f
logic/muldiv_pkg.sv
logic/hilo_wb_if.sv
logic/seq_divider.sv
logic/muldiv_unit.sv
logic/hilo_regs.sv
logic/muldiv_top.sv
tests/muldiv_sva.sv
tests/tb_muldiv.sv

//--- tests/muldiv_sva.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_sva import muldiv_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              flush,
    input logic              req_valid,
    input logic              req_ready,
    input muldiv_op_e        req_op,
    input logic              req_unsigned,
    input logic [DATA_W-1:0] req_a,
    input logic [DATA_W-1:0] req_b,
    input logic              resp_valid,
    input logic              resp_ready,
    input logic [DATA_W-1:0] resp_hi,
    input logic [DATA_W-1:0] resp_lo,
    input logic              div_busy
);

    int unsigned failures = 0;

    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable({req_op, req_unsigned, req_a, req_b}))
    else begin
        failures++;
        $error("Request was dropped or changed before its transfer.");
    end

    // A stalled response holds its data. A flush is allowed to drop it.
    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready && !flush |=> resp_valid && $stable({resp_hi, resp_lo}))
    else begin
        failures++;
        $error("Response was dropped or changed while stalled.");
    end

    assert property (@(posedge clk) $rose(rst_n) |-> !resp_valid && req_ready && !div_busy)
    else begin
        failures++;
        $error("Unit is not idle after reset.");
    end

    assert property (@(posedge clk) disable iff (!rst_n) flush |=> !resp_valid)
    else begin
        failures++;
        $error("Response is valid after a flush.");
    end

    // No new request while a division runs or a response is held.
    assert property (@(posedge clk) disable iff (!rst_n) resp_valid || div_busy |-> !req_ready)
    else begin
        failures++;
        $error("Request ready while the unit is busy.");
    end

endmodule

bind muldiv_top muldiv_sva u_sva (.*);

`default_nettype wire

//--- tests/tb_muldiv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

    localparam int MAX_OPS = 48;  // Upper bound on the operations issued by all tests.

    logic              clk = 1'b0;
    logic              rst_n;
    logic              flush;
    logic              req_valid;
    logic              req_ready;
    muldiv_op_e        req_op;
    logic              req_unsigned;
    logic [DATA_W-1:0] req_a;
    logic [DATA_W-1:0] req_b;
    logic              resp_valid;
    logic              resp_ready;
    logic [DATA_W-1:0] resp_hi;
    logic [DATA_W-1:0] resp_lo;
    logic              mthi;
    logic              mtlo;
    logic [DATA_W-1:0] move_data;
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;

    logic [DATA_W-1:0] model_hi;  // Expected architectural HI/LO.
    logic [DATA_W-1:0] model_lo;
    int                errors = 0;
    int                checks = 0;

    muldiv_top u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [WIDE_W-1:0] mul_model(input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b,
                                                    input logic              uns);
        logic signed [WIDE_W-1:0] sa;
        logic signed [WIDE_W-1:0] sb;
        sa = uns ? {{DATA_W{1'b0}}, a} : {{DATA_W{a[DATA_W-1]}}, a};
        sb = uns ? {{DATA_W{1'b0}}, b} : {{DATA_W{b[DATA_W-1]}}, b};
        return sa * sb;
    endfunction

    // Returns {remainder, quotient}. Wide signed division keeps MIN / -1 exact.
    function automatic logic [WIDE_W-1:0] div_model(input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b,
                                                    input logic              uns);
        logic signed [WIDE_W-1:0] sa;
        logic signed [WIDE_W-1:0] sb;
        logic signed [WIDE_W-1:0] q;
        logic signed [WIDE_W-1:0] r;
        sa = uns ? {{DATA_W{1'b0}}, a} : {{DATA_W{a[DATA_W-1]}}, a};
        sb = uns ? {{DATA_W{1'b0}}, b} : {{DATA_W{b[DATA_W-1]}}, b};
        if (b == '0) begin
            return {a, (!uns && a[DATA_W-1]) ? 32'd1 : 32'hFFFF_FFFF};
        end
        q = sa / sb;
        r = sa % sb;
        return {r[DATA_W-1:0], q[DATA_W-1:0]};
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("mismatch at %0t: %s expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    // Holds the request until the DUT takes it; returns just after the acceptance edge.
    task automatic issue_request(input muldiv_op_e op, input logic uns,
                                 input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        req_valid    = 1'b1;
        req_op       = op;
        req_unsigned = uns;
        req_a        = a;
        req_b        = b;
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic run_op(input muldiv_op_e op, input logic uns, input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b, input int stall);
        logic [WIDE_W-1:0] product;
        logic [WIDE_W-1:0] expected;
        int                latency;
        product = mul_model(a, b, uns);
        case (op)
            OP_DIV:  expected = div_model(a, b, uns);
            OP_MADD: expected = {model_hi, model_lo} + product;
            OP_MSUB: expected = {model_hi, model_lo} - product;
            default: expected = product;
        endcase
        resp_ready = (stall == 0);
        issue_request(op, uns, a, b);
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!resp_valid);
        check_word("response latency", (op == OP_DIV) ? DIV_LATENCY : 1, latency);
        check_word("resp_hi", expected[WIDE_W-1:DATA_W], resp_hi);
        check_word("resp_lo", expected[DATA_W-1:0], resp_lo);
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #2;
            resp_ready = (i == stall - 1);  // Released for the following edge.
            @(negedge clk);
            check_bit("resp_valid", 1'b1, resp_valid);
            check_bit("req_ready", 1'b0, req_ready);
            check_word("resp_hi", expected[WIDE_W-1:DATA_W], resp_hi);
            check_word("resp_lo", expected[DATA_W-1:0], resp_lo);
            check_word("hi", model_hi, hi);
            check_word("lo", model_lo, lo);
        end
        @(posedge clk);  // Response transfer.
        if (op != OP_MUL) begin
            {model_hi, model_lo} = expected;
        end
        @(negedge clk);
        check_bit("resp_valid", 1'b0, resp_valid);
        check_bit("req_ready", 1'b1, req_ready);
        check_word("hi", model_hi, hi);
        check_word("lo", model_lo, lo);
        @(posedge clk);
        #2;
    endtask

    task automatic move_hilo(input logic [DATA_W-1:0] hi_val, input logic [DATA_W-1:0] lo_val);
        mthi      = 1'b1;
        move_data = hi_val;
        @(posedge clk);
        #2;
        mthi      = 1'b0;
        mtlo      = 1'b1;
        move_data = lo_val;
        @(posedge clk);
        #2;
        mtlo     = 1'b0;
        model_hi = hi_val;
        model_lo = lo_val;
        check_word("hi", model_hi, hi);
        check_word("lo", model_lo, lo);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_word("hi", 32'd0, hi);
        check_word("lo", 32'd0, lo);
        check_bit("req_ready", 1'b1, req_ready);
        check_bit("resp_valid", 1'b0, resp_valid);
        @(posedge clk);
        #2;
    endtask

    task automatic test_multiplies();
        logic [DATA_W-1:0] corner_a [4];
        logic [DATA_W-1:0] corner_b [4];
        corner_a = '{32'h8000_0000, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000};
        corner_b = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h1234_5678};
        for (int i = 0; i < 4; i++) begin
            for (int u = 0; u < 2; u++) begin
                run_op(OP_MULT, u[0], corner_a[i], corner_b[i], 0);
                run_op(OP_MUL, u[0], corner_b[i], corner_a[i], 0);  // HI/LO must stay put.
            end
        end
        for (int i = 0; i < 6; i++) begin
            run_op(i[1] ? OP_MUL : OP_MULT, i[0], $urandom, $urandom, 0);
        end
    endtask

    task automatic test_accumulates();
        move_hilo(32'h0000_0001, 32'hFFFF_FFF0);
        for (int i = 0; i < 6; i++) begin
            run_op(i[0] ? OP_MSUB : OP_MADD, i[1], $urandom, $urandom, 0);
        end
        check_word("hi", model_hi, hi);
        check_word("lo", model_lo, lo);
    endtask

    task automatic test_divides();
        run_op(OP_DIV, 1'b0, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        run_op(OP_DIV, 1'b0, 32'hFFFF_FFF9, 32'd2, 0);
        run_op(OP_DIV, 1'b0, 32'd7, 32'hFFFF_FFFE, 0);
        run_op(OP_DIV, 1'b0, 32'hFFFF_FF00, 32'd0, 0);
        run_op(OP_DIV, 1'b1, 32'hFFFF_FF00, 32'd0, 0);
        run_op(OP_DIV, 1'b1, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        for (int i = 0; i < 6; i++) begin
            run_op(OP_DIV, i[0], $urandom, $urandom >> (4 * i), 0);  // Shorter divisors too.
        end
    endtask

    task automatic test_backpressure();
        run_op(OP_MULT, 1'b0, $urandom, $urandom, $urandom_range(8, 2));
        run_op(OP_MADD, 1'b1, $urandom, $urandom, $urandom_range(8, 2));
        run_op(OP_DIV, 1'b0, $urandom, $urandom >> 8, $urandom_range(8, 2));
        run_op(OP_MUL, 1'b0, $urandom, $urandom, $urandom_range(8, 2));
    endtask

    task automatic test_flush();
        resp_ready = 1'b1;
        issue_request(OP_DIV, 1'b0, $urandom, 32'd3);
        repeat (10) @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        for (int i = 0; i < DIV_LATENCY + 4; i++) begin
            @(negedge clk);
            check_bit("resp_valid", 1'b0, resp_valid);
            check_word("hi", model_hi, hi);
            check_word("lo", model_lo, lo);
        end
        check_bit("div_busy", 1'b0, u_dut.div_busy);
        @(posedge clk);
        #2;
        run_op(OP_MULT, 1'b0, $urandom, $urandom, 0);
    endtask

    initial begin
        void'($urandom(32'h2115_1a3a));
        rst_n        = 1'b0;
        flush        = 1'b0;
        req_valid    = 1'b0;
        req_op       = OP_MULT;
        req_unsigned = 1'b0;
        req_a        = '0;
        req_b        = '0;
        resp_ready   = 1'b1;
        mthi         = 1'b0;
        mtlo         = 1'b0;
        move_data    = '0;
        model_hi     = '0;
        model_lo     = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_multiplies();
        test_accumulates();
        test_divides();
        test_backpressure();
        test_flush();
        errors += u_dut.u_sva.failures;  // Concurrent assertion failures count as errors.
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (MAX_OPS * (DIV_LATENCY + 10) + 200) @(posedge clk);
        $display("Timeout: the tests did not finish within the cycle limit.");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
